// ==== src/tile_router_pkg.sv ====
// tile router package
// address layout, port counts and shared types for the tile request router
`default_nettype none

package tile_router_pkg;

  localparam int unsigned NumCoresPerTile  = 4;
  // port 0 is local, the rest lead to other tiles
  localparam int unsigned NumRemotePorts   = 4;
  localparam int unsigned NumExtPorts      = NumRemotePorts - 1;
  localparam int unsigned NumBanksPerTile  = 8;
  localparam int unsigned NumTilesPerGroup = 4;
  localparam int unsigned NumGroups        = 4;
  localparam int unsigned ByteOffset       = 2;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // address layout: byte offset, bank, tile, group, row
  localparam int unsigned BankLsb    = ByteOffset;
  localparam int unsigned BankWidth  = $clog2(NumBanksPerTile);
  localparam int unsigned GroupLsb   = BankLsb + BankWidth + $clog2(NumTilesPerGroup);
  localparam int unsigned GroupWidth = $clog2(NumGroups);
  localparam int unsigned RowLsb     = GroupLsb + GroupWidth;
  localparam int unsigned RowWidth   = BankWidth;

  localparam int unsigned CoreIdxWidth = $clog2(NumCoresPerTile);
  localparam int unsigned PortSelWidth = $clog2(NumRemotePorts);

  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } tcdm_op_e;

  // occupancy of an arbiter output slot
  typedef enum logic {
    PortIdle = 1'b0,
    PortFull = 1'b1
  } port_state_e;

  // cores sharing remote port (1 + port), core c goes to port c mod NumExtPorts
  function automatic int unsigned clients_of_port(input int unsigned port);
    return (NumCoresPerTile - port + NumExtPorts - 1) / NumExtPorts;
  endfunction

endpackage

`default_nettype wire

// ==== src/tile_addr_decode.sv ====
// tile address decode
// picks the local port or a fixed remote port per core, held while a request waits
`timescale 1ns/1ps
`default_nettype none

module tile_addr_decode (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_n_i,
  input  wire logic [tile_router_pkg::GroupWidth-1:0]     group_id_i,
  input  wire logic [tile_router_pkg::NumCoresPerTile-1:0] core_valid_i,
  input  wire logic [tile_router_pkg::NumCoresPerTile-1:0] core_ready_i,
  input  wire logic [tile_router_pkg::NumCoresPerTile-1:0][tile_router_pkg::AddrWidth-1:0]
                                                          core_addr_i,
  output logic      [tile_router_pkg::NumCoresPerTile-1:0] is_local_o,
  output logic      [tile_router_pkg::NumCoresPerTile-1:0][tile_router_pkg::PortSelWidth-1:0]
                                                          tgt_port_o
);

  import tile_router_pkg::*;

  logic [NumCoresPerTile-1:0][PortSelWidth-1:0] sel_d;
  logic [NumCoresPerTile-1:0][PortSelWidth-1:0] sel_q;
  logic [NumCoresPerTile-1:0]                   wait_q;

  // own group goes to port 0, otherwise fixed spread over the remote ports
  always_comb begin
    for (int c = 0; c < NumCoresPerTile; c++) begin
      if (core_addr_i[c][GroupLsb +: GroupWidth] == group_id_i) begin
        sel_d[c] = '0;
      end else begin
        sel_d[c] = PortSelWidth'(1 + (c % NumExtPorts));
      end
    end
  end

  // a request that was not taken keeps waiting until its handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wait_q <= '0;
    end else begin
      wait_q <= core_valid_i & ~core_ready_i;
    end
  end

  // capture the selection in the first cycle of each request
  always_ff @(posedge clk_i) begin
    for (int c = 0; c < NumCoresPerTile; c++) begin
      if (core_valid_i[c] && !wait_q[c]) begin
        sel_q[c] <= sel_d[c];
      end
    end
  end

  always_comb begin
    for (int c = 0; c < NumCoresPerTile; c++) begin
      tgt_port_o[c] = wait_q[c] ? sel_q[c] : sel_d[c];
      is_local_o[c] = (tgt_port_o[c] == '0);
    end
  end

  for (genvar c = 0; c < NumCoresPerTile; c++) begin : gen_chk
    // the target must not move under a stalled request
    a_tgt_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      core_valid_i[c] && !core_ready_i[c] |=> $stable(tgt_port_o[c]));
  end

endmodule

`default_nettype wire

// ==== src/bank_id_remap.sv ====
// bank id remap
// rotates the bank field by the row field on core and slave addresses
`timescale 1ns/1ps
`default_nettype none

module bank_id_remap (
  input  wire logic [tile_router_pkg::NumCoresPerTile-1:0][tile_router_pkg::AddrWidth-1:0]
                    core_addr_i,
  input  wire logic [tile_router_pkg::NumExtPorts-1:0][tile_router_pkg::AddrWidth-1:0]
                    slave_addr_i,
  output logic      [tile_router_pkg::NumCoresPerTile-1:0][tile_router_pkg::AddrWidth-1:0]
                    core_addr_o,
  output logic      [tile_router_pkg::NumExtPorts-1:0][tile_router_pkg::AddrWidth-1:0]
                    slave_addr_o
);

  import tile_router_pkg::*;

  // new bank = old bank + row, wraps modulo the bank count
  function automatic logic [AddrWidth-1:0] remap_addr(input logic [AddrWidth-1:0] addr);
    logic [AddrWidth-1:0] res;
    res = addr;
    res[BankLsb +: BankWidth] = addr[BankLsb +: BankWidth] + addr[RowLsb +: RowWidth];
    return res;
  endfunction

  always_comb begin
    for (int c = 0; c < NumCoresPerTile; c++) begin
      core_addr_o[c] = remap_addr(core_addr_i[c]);
    end
    // incoming requests from other tiles see the same bank mapping
    for (int p = 0; p < NumExtPorts; p++) begin
      slave_addr_o[p] = remap_addr(slave_addr_i[p]);
    end
  end

endmodule

`default_nettype wire

// ==== src/remote_port_arbiter.sv ====
// remote port arbiter
// round-robin grant of the cores sharing one remote port into a one-entry slot
`timescale 1ns/1ps
`default_nettype none

module remote_port_arbiter #(
  parameter int unsigned NumClients = 2
) (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_n_i,
  input  wire logic [NumClients-1:0]                   req_i,
  input  wire logic [NumClients-1:0][tile_router_pkg::AddrWidth-1:0]    addr_i,
  input  wire logic [NumClients-1:0][tile_router_pkg::DataWidth-1:0]    wdata_i,
  input  wire tile_router_pkg::tcdm_op_e [NumClients-1:0]              op_i,
  input  wire logic [NumClients-1:0][tile_router_pkg::CoreIdxWidth-1:0] ini_i,
  input  wire logic                                    remote_ready_i,
  output logic      [NumClients-1:0]                   gnt_o,
  output logic                                         remote_valid_o,
  output logic      [tile_router_pkg::AddrWidth-1:0]    remote_addr_o,
  output logic      [tile_router_pkg::DataWidth-1:0]    remote_wdata_o,
  output tile_router_pkg::tcdm_op_e                    remote_op_o,
  output logic      [tile_router_pkg::CoreIdxWidth-1:0] remote_ini_o
);

  import tile_router_pkg::*;

  port_state_e             state_q;
  logic                    live_q;
  logic                    accept;
  logic                    seen;
  logic [NumClients-1:0]   gnt;
  logic [NumClients-1:0]   prio_q;
  logic [NumClients-1:0]   prio_d;
  logic [AddrWidth-1:0]    addr_sel;
  logic [DataWidth-1:0]    wdata_sel;
  tcdm_op_e                op_sel;
  logic [CoreIdxWidth-1:0] ini_sel;

  // slot takes a new entry when empty or draining this cycle
  assign accept = live_q && ((state_q == PortIdle) || remote_ready_i);

  // scan twice round, starting at the client that holds priority
  always_comb begin
    gnt  = '0;
    seen = 1'b0;
    for (int k = 0; k < 2 * NumClients; k++) begin
      if (prio_q[k % NumClients]) begin
        seen = 1'b1;
      end
      if (seen && accept && req_i[k % NumClients] && gnt == '0) begin
        gnt[k % NumClients] = 1'b1;
      end
    end
  end

  // priority moves to the client after the winner
  always_comb begin
    prio_d = '0;
    for (int i = 0; i < NumClients; i++) begin
      prio_d[(i + 1) % NumClients] = gnt[i];
    end
  end

  always_comb begin
    addr_sel  = '0;
    wdata_sel = '0;
    op_sel    = OpRead;
    ini_sel   = '0;
    for (int i = 0; i < NumClients; i++) begin
      if (gnt[i]) begin
        addr_sel  = addr_i[i];
        wdata_sel = wdata_i[i];
        op_sel    = op_i[i];
        ini_sel   = ini_i[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= PortIdle;
      prio_q  <= NumClients'(1);
      live_q  <= 1'b0;
    end else begin
      // no grant goes out while in reset
      live_q <= 1'b1;
      if (|gnt) begin
        state_q <= PortFull;
        prio_q  <= prio_d;
      end else if (remote_ready_i) begin
        state_q <= PortIdle;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (|gnt) begin
      remote_addr_o  <= addr_sel;
      remote_wdata_o <= wdata_sel;
      remote_op_o    <= op_sel;
      remote_ini_o   <= ini_sel;
    end
  end

  assign gnt_o          = gnt;
  assign remote_valid_o = (state_q == PortFull);

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt));

  // a stalled slot keeps its whole entry
  a_slot_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    remote_valid_o && !remote_ready_i |=> remote_valid_o && $stable(remote_addr_o)
      && $stable(remote_wdata_o) && $stable(remote_op_o) && $stable(remote_ini_o));

endmodule

`default_nettype wire

// ==== src/tile_router.sv ====
// tile request router
// steers core requests to local or remote ports, remaps banks on all forwarded addresses
`timescale 1ns/1ps
`default_nettype none

module tile_router (
  input  wire logic                                        clk_i,
  input  wire logic                                        rst_n_i,
  input  wire logic [tile_router_pkg::GroupWidth-1:0]      group_id_i,
  input  wire logic [tile_router_pkg::NumCoresPerTile-1:0] core_valid_i,
  input  wire logic [tile_router_pkg::NumCoresPerTile-1:0][tile_router_pkg::AddrWidth-1:0]
                                                           core_addr_i,
  input  wire logic [tile_router_pkg::NumCoresPerTile-1:0][tile_router_pkg::DataWidth-1:0]
                                                           core_wdata_i,
  input  wire tile_router_pkg::tcdm_op_e [tile_router_pkg::NumCoresPerTile-1:0] core_op_i,
  output logic      [tile_router_pkg::NumCoresPerTile-1:0] core_ready_o,
  output logic      [tile_router_pkg::NumCoresPerTile-1:0] local_valid_o,
  output logic      [tile_router_pkg::NumCoresPerTile-1:0][tile_router_pkg::AddrWidth-1:0]
                                                           local_addr_o,
  output logic      [tile_router_pkg::NumCoresPerTile-1:0][tile_router_pkg::DataWidth-1:0]
                                                           local_wdata_o,
  output tile_router_pkg::tcdm_op_e [tile_router_pkg::NumCoresPerTile-1:0] local_op_o,
  input  wire logic [tile_router_pkg::NumCoresPerTile-1:0] local_ready_i,
  output logic      [tile_router_pkg::NumExtPorts-1:0]     remote_valid_o,
  output logic      [tile_router_pkg::NumExtPorts-1:0][tile_router_pkg::AddrWidth-1:0]
                                                           remote_addr_o,
  output logic      [tile_router_pkg::NumExtPorts-1:0][tile_router_pkg::DataWidth-1:0]
                                                           remote_wdata_o,
  output tile_router_pkg::tcdm_op_e [tile_router_pkg::NumExtPorts-1:0] remote_op_o,
  output logic      [tile_router_pkg::NumExtPorts-1:0][tile_router_pkg::CoreIdxWidth-1:0]
                                                           remote_ini_o,
  input  wire logic [tile_router_pkg::NumExtPorts-1:0]     remote_ready_i,
  input  wire logic [tile_router_pkg::NumExtPorts-1:0]     slave_valid_i,
  input  wire logic [tile_router_pkg::NumExtPorts-1:0][tile_router_pkg::AddrWidth-1:0]
                                                           slave_addr_i,
  output logic      [tile_router_pkg::NumExtPorts-1:0]     slave_valid_o,
  output logic      [tile_router_pkg::NumExtPorts-1:0][tile_router_pkg::AddrWidth-1:0]
                                                           slave_addr_o
);

  import tile_router_pkg::*;

  logic [NumCoresPerTile-1:0]                   is_local;
  logic [NumCoresPerTile-1:0][PortSelWidth-1:0] tgt_port;
  logic [NumCoresPerTile-1:0][AddrWidth-1:0]    core_addr_remap;
  logic [NumCoresPerTile-1:0]                   core_ready;
  wire  [NumCoresPerTile-1:0]                   core_gnt;

  tile_addr_decode i_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .group_id_i   (group_id_i),
    .core_valid_i (core_valid_i),
    .core_ready_i (core_ready),
    .core_addr_i  (core_addr_i),
    .is_local_o   (is_local),
    .tgt_port_o   (tgt_port)
  );

  bank_id_remap i_remap (
    .core_addr_i  (core_addr_i),
    .slave_addr_i (slave_addr_i),
    .core_addr_o  (core_addr_remap),
    .slave_addr_o (slave_addr_o)
  );

  // local path, no register
  assign local_valid_o = core_valid_i & is_local;
  assign local_addr_o  = core_addr_remap;
  assign local_wdata_o = core_wdata_i;
  assign local_op_o    = core_op_i;

  always_comb begin
    for (int c = 0; c < NumCoresPerTile; c++) begin
      core_ready[c] = is_local[c] ? local_ready_i[c] : core_gnt[c];
    end
  end

  assign core_ready_o = core_ready;

  // per-port view: client k of port p is core p + k * NumExtPorts
  for (genvar p = 0; p < NumExtPorts; p++) begin : gen_port
    logic     [clients_of_port(p)-1:0]                   req;
    logic     [clients_of_port(p)-1:0]                   gnt;
    logic     [clients_of_port(p)-1:0][AddrWidth-1:0]    addr;
    logic     [clients_of_port(p)-1:0][DataWidth-1:0]    wdata;
    tcdm_op_e [clients_of_port(p)-1:0]                   op;
    logic     [clients_of_port(p)-1:0][CoreIdxWidth-1:0] ini;

    for (genvar k = 0; k < clients_of_port(p); k++) begin : gen_client
      assign req[k]   = core_valid_i[p + k * NumExtPorts]
                        && (tgt_port[p + k * NumExtPorts] == PortSelWidth'(p + 1));
      assign addr[k]  = core_addr_remap[p + k * NumExtPorts];
      assign wdata[k] = core_wdata_i[p + k * NumExtPorts];
      assign op[k]    = core_op_i[p + k * NumExtPorts];
      assign ini[k]   = CoreIdxWidth'(p + k * NumExtPorts);
      assign core_gnt[p + k * NumExtPorts] = gnt[k];
    end

    remote_port_arbiter #(
      .NumClients (clients_of_port(p))
    ) i_arb (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .req_i          (req),
      .addr_i         (addr),
      .wdata_i        (wdata),
      .op_i           (op),
      .ini_i          (ini),
      .remote_ready_i (remote_ready_i[p]),
      .gnt_o          (gnt),
      .remote_valid_o (remote_valid_o[p]),
      .remote_addr_o  (remote_addr_o[p]),
      .remote_wdata_o (remote_wdata_o[p]),
      .remote_op_o    (remote_op_o[p]),
      .remote_ini_o   (remote_ini_o[p])
    );
  end

  // slave ready belongs to the bank side
  assign slave_valid_o = slave_valid_i;

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// testbench clock source
// free running clock with a 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== bench/tb_tile_router.sv ====
// testbench for the tile request router
// replays the pattern file through the core ports and checks local, remote and slave ports
`timescale 1ns/1ps
`default_nettype none

module tb_tile_router;

  import tile_router_pkg::*;

  localparam int NumPat      = 9;
  localparam int NumFields   = 9;
  localparam int Timeout     = 50;
  localparam int ResetCycles = 16;
  // column positions in one pattern line
  localparam int FCore     = 0;
  localparam int FGroup    = 1;
  localparam int FAddr     = 2;
  localparam int FWdata    = 3;
  localparam int FOp       = 4;
  localparam int FLocal    = 5;
  localparam int FExpAddr  = 6;
  localparam int FPort     = 7;
  localparam int FBp       = 8;

  logic                                      clk;
  logic                                      rst_n;
  logic [GroupWidth-1:0]                     group_id;
  logic [NumCoresPerTile-1:0]                core_valid;
  logic [NumCoresPerTile-1:0]                core_ready;
  logic [NumCoresPerTile-1:0][AddrWidth-1:0] core_addr;
  logic [NumCoresPerTile-1:0][DataWidth-1:0] core_wdata;
  tcdm_op_e [NumCoresPerTile-1:0]            core_op;
  logic [NumCoresPerTile-1:0]                local_valid;
  logic [NumCoresPerTile-1:0]                local_ready;
  logic [NumCoresPerTile-1:0][AddrWidth-1:0] local_addr;
  logic [NumCoresPerTile-1:0][DataWidth-1:0] local_wdata;
  tcdm_op_e [NumCoresPerTile-1:0]            local_op;
  logic [NumExtPorts-1:0]                    remote_valid;
  logic [NumExtPorts-1:0]                    remote_ready;
  logic [NumExtPorts-1:0][AddrWidth-1:0]     remote_addr;
  logic [NumExtPorts-1:0][DataWidth-1:0]     remote_wdata;
  tcdm_op_e [NumExtPorts-1:0]                remote_op;
  logic [NumExtPorts-1:0][CoreIdxWidth-1:0]  remote_ini;
  logic [NumExtPorts-1:0]                    slave_valid_in;
  logic [NumExtPorts-1:0]                    slave_valid_out;
  logic [NumExtPorts-1:0][AddrWidth-1:0]     slave_addr_in;
  logic [NumExtPorts-1:0][AddrWidth-1:0]     slave_addr_out;

  logic [31:0] pat_mem [0:NumPat*NumFields-1];
  int          seed = 73;
  int          errors = 0;
  int          test_errs = 0;
  int          tests = 0;
  int          failed = 0;

  tb_clock_gen clock_gen (
    .clk_o (clk)
  );

  tile_router tile_router_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .group_id_i     (group_id),
    .core_valid_i   (core_valid),
    .core_addr_i    (core_addr),
    .core_wdata_i   (core_wdata),
    .core_op_i      (core_op),
    .core_ready_o   (core_ready),
    .local_valid_o  (local_valid),
    .local_addr_o   (local_addr),
    .local_wdata_o  (local_wdata),
    .local_op_o     (local_op),
    .local_ready_i  (local_ready),
    .remote_valid_o (remote_valid),
    .remote_addr_o  (remote_addr),
    .remote_wdata_o (remote_wdata),
    .remote_op_o    (remote_op),
    .remote_ini_o   (remote_ini),
    .remote_ready_i (remote_ready),
    .slave_valid_i  (slave_valid_in),
    .slave_addr_i   (slave_addr_in),
    .slave_valid_o  (slave_valid_out),
    .slave_addr_o   (slave_addr_out)
  );

  function automatic logic [31:0] field(input int i, input int f);
    return pat_mem[i * NumFields + f];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %08h expected %08h", name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // outputs are read at the falling edge
  task automatic settle();
    @(negedge clk);
  endtask

  task automatic wait_ready(input int c);
    int n;
    n = 0;
    while (core_ready[c] !== 1'b1 && n < Timeout) begin
      next_cycle();
      settle();
      n++;
    end
    if (core_ready[c] !== 1'b1) begin
      $display("timeout: core %0d got no ready within %0d cycles", c, Timeout);
      errors++;
      test_errs++;
    end
  endtask

  task automatic drive_core(input int i);
    int   c;
    logic op_bit;
    c             = field(i, FCore);
    op_bit        = (field(i, FOp) != 0);
    group_id      = GroupWidth'(field(i, FGroup));
    core_valid[c] = 1'b1;
    core_addr[c]  = field(i, FAddr);
    core_wdata[c] = field(i, FWdata);
    core_op[c]    = tcdm_op_e'(op_bit);
  endtask

  task automatic check_remote(input int i);
    int p;
    p = field(i, FPort) - 1;
    check($sformatf("remote_valid_o[%0d]", p), 32'(remote_valid[p]), 1);
    check($sformatf("remote_addr_o[%0d]", p), remote_addr[p], field(i, FExpAddr));
    check($sformatf("remote_wdata_o[%0d]", p), remote_wdata[p], field(i, FWdata));
    check($sformatf("remote_op_o[%0d]", p), 32'(remote_op[p]), field(i, FOp));
    check($sformatf("remote_ini_o[%0d]", p), 32'(remote_ini[p]), field(i, FCore));
  endtask

  task automatic check_local(input int i);
    int c;
    c = field(i, FCore);
    check($sformatf("local_valid_o[%0d]", c), 32'(local_valid[c]), 1);
    check($sformatf("local_addr_o[%0d]", c), local_addr[c], field(i, FExpAddr));
    check($sformatf("local_wdata_o[%0d]", c), local_wdata[c], field(i, FWdata));
    check($sformatf("local_op_o[%0d]", c), 32'(local_op[c]), field(i, FOp));
    check($sformatf("core_ready_o[%0d]", c), 32'(core_ready[c]), 32'(local_ready[c]));
    check("remote_valid_o", 32'(remote_valid), 0);
  endtask

  task automatic check_slave(input int i);
    for (int k = 0; k < NumExtPorts; k++) begin
      check($sformatf("slave_addr_o[%0d]", k), slave_addr_out[k], field(i, FExpAddr));
    end
    check("slave_valid_o", 32'(slave_valid_out), 32'(slave_valid_in));
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errs);
      failed++;
    end
    test_errs = 0;
  endtask

  task automatic run_pattern(input int i);
    int c;
    int p;
    int bp;
    c  = field(i, FCore);
    p  = field(i, FPort) - 1;
    bp = field(i, FBp);
    drive_core(i);
    slave_addr_in  = {NumExtPorts{field(i, FAddr)}};
    slave_valid_in = 3'b101;
    if (field(i, FLocal) != 0) begin
      // bank busy for bp cycles, core must see ready low
      local_ready[c] = 1'b0;
      for (int n = 0; n < bp; n++) begin
        settle();
        check_local(i);
        check_slave(i);
        next_cycle();
      end
      local_ready[c] = 1'b1;
      settle();
      wait_ready(c);
      check_local(i);
      check_slave(i);
      next_cycle();
      core_valid[c] = 1'b0;
      slave_valid_in = '0;
      settle();
      check($sformatf("local_valid_o[%0d]", c), 32'(local_valid[c]), 0);
    end else begin
      remote_ready[p] = (bp == 0);
      settle();
      check_slave(i);
      check($sformatf("local_valid_o[%0d]", c), 32'(local_valid[c]), 0);
      wait_ready(c);
      // slot shows the request one cycle later and holds it while ready is low
      for (int n = 0; n <= bp; n++) begin
        next_cycle();
        core_valid[c] = 1'b0;
        if (n == bp) begin
          remote_ready[p] = 1'b1;
        end
        settle();
        check_remote(i);
      end
      next_cycle();
      slave_valid_in = '0;
      settle();
      check($sformatf("remote_valid_o[%0d]", p), 32'(remote_valid[p]), 0);
    end
    check("slave_valid_o", 32'(slave_valid_out), 0);
  endtask

  initial begin
    rst_n          = 1'b0;
    group_id       = '0;
    core_valid     = '0;
    core_addr      = '0;
    core_wdata     = '0;
    for (int c = 0; c < NumCoresPerTile; c++) begin
      core_op[c] = OpRead;
    end
    local_ready    = '1;
    remote_ready   = '1;
    slave_valid_in = '0;
    slave_addr_in  = '0;

    $readmemh("bench/router_patterns.txt", pat_mem);
    for (int i = 0; i < NumPat; i++) begin
      if (pat_mem[i * NumFields + FWdata] == 0) begin
        pat_mem[i * NumFields + FWdata] = $random(seed);
      end
    end

    // cores 0 and 3 ask for remote port 1 while reset is still held
    drive_core(0);
    drive_core(1);
    for (int n = 0; n < ResetCycles - 1; n++) begin
      next_cycle();
      settle();
      check("remote_valid_o", 32'(remote_valid), 0);
      check("core_ready_o[0]", 32'(core_ready[0]), 0);
      check("core_ready_o[3]", 32'(core_ready[3]), 0);
    end
    finish_test("reset");

    next_cycle();
    rst_n = 1'b1;
    settle();
    wait_ready(0);
    check("core_ready_o[3]", 32'(core_ready[3]), 0);
    next_cycle();
    core_valid[0] = 1'b0;
    settle();
    check_remote(0);
    // core 3 gets the slot in the cycle it drains
    wait_ready(3);
    next_cycle();
    core_valid[3] = 1'b0;
    settle();
    check_remote(1);
    next_cycle();
    settle();
    check("remote_valid_o[0]", 32'(remote_valid[0]), 0);
    finish_test("contention");

    next_cycle();
    remote_ready[0] = 1'b0;
    drive_core(0);
    settle();
    wait_ready(0);
    next_cycle();
    core_valid[0] = 1'b0;
    drive_core(1);
    for (int n = 0; n < field(0, FBp); n++) begin
      settle();
      check_remote(0);
      check("core_ready_o[3]", 32'(core_ready[3]), 0);
      next_cycle();
    end
    remote_ready[0] = 1'b1;
    settle();
    check_remote(0);
    wait_ready(3);
    next_cycle();
    core_valid[3] = 1'b0;
    settle();
    check_remote(1);
    next_cycle();
    settle();
    check("remote_valid_o[0]", 32'(remote_valid[0]), 0);
    finish_test("backpressure");

    for (int i = 0; i < NumPat; i++) begin
      next_cycle();
      run_pattern(i);
      finish_test($sformatf("pattern %0d", i));
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/router_patterns.txt ====
// core group_id addr wdata op local exp_addr port backpressure
// wdata 0 is replaced by a random word, port 0 is the local port
0 0 10000738 00000000 1 0 10000724 1 3
3 0 20000bd0 cafef00d 0 0 20000bc4 1 0
1 1 00001eea 12345678 1 1 00001ee6 0 2
1 1 8000021c 00000000 0 0 80000200 2 2
2 3 000004b4 0badf00d 1 0 000004bc 3 1
2 3 ffff098c 00000000 0 1 ffff099c 0 0
3 2 00abcd44 deadbeef 1 1 00abcd5c 0 1
0 2 00000014 00000000 0 0 00000014 1 0
3 1 40000f7c 55aa55aa 1 0 40000f78 1 4

// ==== all.f ====
src/tile_router_pkg.sv
src/tile_addr_decode.sv
src/bank_id_remap.sv
src/remote_port_arbiter.sv
src/tile_router.sv
bench/tb_clock_gen.sv
bench/tb_tile_router.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the tile router testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_tile_router -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_tile_router > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$log"; then
  exit 0
fi
exit 1
